//--- source/gmii_mac_pkg.sv
`default_nettype none

package gmii_mac_pkg;

    localparam logic [7:0]  preamble_byte = 8'h55;
    localparam logic [7:0]  sfd_byte      = 8'hD5;
    localparam int          preamble_len  = 7;
    localparam int          fcs_len       = 4;
    localparam int          ifg_cycles    = 12;
    localparam logic [31:0] crc_init      = 32'h0;
    localparam logic [31:0] crc_residue   = 32'hC704DD7B;
    localparam logic [31:0] crc_poly      = 32'h04C11DB7; // IEEE 802.3, msb-first register

    typedef enum logic [2:0] {
        TX_IDLE,
        TX_PREAMBLE,
        TX_SFD,
        TX_DATA,
        TX_FCS,
        TX_GAP
    } tx_state_t;

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_PREAMBLE,
        RX_DATA,
        RX_DISCARD
    } rx_state_t;

    typedef enum logic [7:0] {
        REG_STATUS    = 8'h00,
        REG_TX_DATA   = 8'h04,
        REG_TX_COMMIT = 8'h08,
        REG_RX_LEN    = 8'h0C,
        REG_RX_DATA   = 8'h10,
        REG_RX_NEXT   = 8'h14
    } reg_addr_t;

    // one byte through the serial LFSR, d[0] goes first on the wire
    function automatic logic [31:0] crc32_next_byte(input logic [7:0] d, input logic [31:0] c);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int i = 0; i < 8; i++) begin
            fb = r[31] ^ d[i];
            r  = {r[30:0], 1'b0};
            if (fb)
                r = r ^ crc_poly;
        end
        return r;
    endfunction

    function automatic logic [7:0] fcs_byte(input logic [31:0] crc, input logic [1:0] idx);
        logic [7:0] b;
        logic [7:0] r;
        b = crc[8 * (3 - idx) +: 8]; // idx 0 is the high byte
        for (int i = 0; i < 8; i++)
            r[i] = b[7 - i];
        return ~r;
    endfunction

endpackage

`default_nettype wire

//--- source/packet_ring.sv
`timescale 1ns/1ps
`default_nettype none

module packet_ring #(
    parameter int  NUM_SLOTS  = 4,
    parameter int  MAX_PACKET = 64,
    localparam int LEN_W      = $clog2(MAX_PACKET + 1)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             push,
    input  logic [7:0]       push_data,
    input  logic             commit,
    input  logic             drop,
    output logic             space_ok,
    output logic             slot_free,
    input  logic [LEN_W-1:0] rd_offset,
    input  logic             release_head,
    output logic             head_valid,
    output logic [LEN_W-1:0] head_len,
    output logic [7:0]       rd_data
);

    localparam int SLOT_W = $clog2(NUM_SLOTS);
    localparam int OFF_W  = $clog2(MAX_PACKET);

    logic [7:0]       mem     [NUM_SLOTS][MAX_PACKET];
    logic [LEN_W-1:0] len_tab [NUM_SLOTS];
    logic [SLOT_W-1:0] head;
    logic [SLOT_W-1:0] tail;   // slot being filled
    logic [SLOT_W:0]   used;   // committed slots
    logic [LEN_W-1:0]  fill;

    assign space_ok   = fill < MAX_PACKET;
    assign slot_free  = used < NUM_SLOTS;
    assign head_valid = used != '0;
    assign head_len   = len_tab[head];

    always_ff @(posedge clock) begin
        if (!reset) begin
            head <= '0;
            tail <= '0;
            used <= '0;
            fill <= '0;
        end else begin
            if (commit) begin
                tail <= tail + 1'b1;
                fill <= '0;
            end else if (drop) begin
                fill <= '0;
            end else if (push) begin
                fill <= fill + 1'b1;
            end

            if (release_head)
                head <= head + 1'b1;

            if (commit && !release_head)
                used <= used + 1'b1;
            else if (release_head && !commit)
                used <= used - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (push)
            mem[tail][fill[OFF_W-1:0]] <= push_data;
        if (commit)
            len_tab[tail] <= fill;
        rd_data <= mem[head][rd_offset[OFF_W-1:0]]; // one cycle read latency
    end

endmodule

`default_nettype wire

//--- source/mac_tx.sv
`timescale 1ns/1ps
`default_nettype none

module mac_tx
    import gmii_mac_pkg::*;
#(
    parameter int  MAX_PACKET = 64,
    localparam int LEN_W      = $clog2(MAX_PACKET + 1)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             head_valid,
    input  logic [LEN_W-1:0] head_len,
    output logic [LEN_W-1:0] rd_offset,
    input  logic [7:0]       rd_data,
    output logic             release_head,
    output logic [7:0]       tx_data,
    output logic             tx_en
);

    tx_state_t        state;
    logic [LEN_W-1:0] count;   // shared by preamble, data, fcs and gap
    logic [31:0]      crc;

    // ring data is registered, so the offset runs one byte ahead of the line
    assign rd_offset    = (state == TX_SFD || state == TX_DATA) ? count + 1'b1 : '0;
    assign release_head = (state == TX_FCS) && (count == fcs_len);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= TX_IDLE;
            count <= '0;
            tx_en <= 1'b0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (head_valid) begin
                        state <= TX_PREAMBLE;
                        tx_en <= 1'b1;
                        count <= 1;
                    end
                end
                TX_PREAMBLE: begin
                    if (count == preamble_len) begin
                        state <= TX_SFD;
                        count <= '0;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                TX_SFD: begin
                    state <= TX_DATA;
                    count <= 1;                 // byte 0 on the line
                end
                TX_DATA: begin
                    if (count == head_len) begin
                        state <= TX_FCS;
                        count <= 1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                TX_FCS: begin
                    if (count == fcs_len) begin
                        state <= TX_GAP;
                        tx_en <= 1'b0;
                        count <= 1;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                TX_GAP: begin
                    if (count == ifg_cycles)
                        state <= TX_IDLE;
                    else
                        count <= count + 1'b1;
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        case (state)
            TX_IDLE:
                tx_data <= head_valid ? preamble_byte : 8'h00;
            TX_PREAMBLE: begin
                tx_data <= (count == preamble_len) ? sfd_byte : preamble_byte;
                crc     <= crc_init;
            end
            TX_SFD: begin
                tx_data <= rd_data;
                crc     <= crc32_next_byte(rd_data, crc);
            end
            TX_DATA: begin
                if (count == head_len) begin
                    tx_data <= fcs_byte(crc, 2'd0);
                end else begin
                    tx_data <= rd_data;
                    crc     <= crc32_next_byte(rd_data, crc);
                end
            end
            TX_FCS:
                tx_data <= (count == fcs_len) ? 8'h00 : fcs_byte(crc, count[1:0]);
            default:
                tx_data <= 8'h00;
        endcase
    end

endmodule

`default_nettype wire

//--- source/mac_rx.sv
`timescale 1ns/1ps
`default_nettype none

module mac_rx
    import gmii_mac_pkg::*;
#(
    parameter int  MAX_PACKET = 64,
    localparam int LEN_W      = $clog2(MAX_PACKET + 1)
) (
    input  logic       clock,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_dv,
    input  logic       rx_er,
    output logic       push,
    output logic [7:0] push_data,
    output logic       commit,
    output logic       drop,
    input  logic       space_ok,
    input  logic       slot_free,
    output logic       rx_drop
);

    rx_state_t        state;
    logic [LEN_W-1:0] count;             // preamble bytes, then frame bytes
    logic [31:0]      crc;
    logic [7:0]       hold [fcs_len];    // last bytes held back, fcs never stored
    logic             start;
    logic             take;
    logic             crc_good;

    assign start = (state == RX_PREAMBLE) && rx_dv && !rx_er && rx_data == sfd_byte
                   && count == preamble_len && slot_free;
    assign take  = (state == RX_DATA) && rx_dv && !rx_er && count != MAX_PACKET && space_ok;
    assign crc_good = (crc == crc_residue) && (count >= fcs_len + 1) && slot_free;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state   <= RX_IDLE;
            count   <= '0;
            push    <= 1'b0;
            commit  <= 1'b0;
            drop    <= 1'b0;
            rx_drop <= 1'b0;
        end else begin
            push    <= take && count >= fcs_len;
            commit  <= 1'b0;
            drop    <= 1'b0;
            rx_drop <= 1'b0;
            case (state)
                RX_IDLE: begin
                    count <= 1;
                    if (rx_dv)
                        state <= (rx_data == preamble_byte && !rx_er) ? RX_PREAMBLE : RX_DISCARD;
                end
                RX_PREAMBLE: begin
                    if (!rx_dv) begin
                        state <= RX_IDLE;   // nothing stored yet
                    end else if (start) begin
                        state <= RX_DATA;
                        count <= '0;
                    end else if (!rx_er && rx_data == preamble_byte && count < preamble_len) begin
                        count <= count + 1'b1;
                    end else begin
                        state <= RX_DISCARD; // bad preamble, full ring or rx_er
                    end
                end
                RX_DATA: begin
                    if (!rx_dv) begin
                        state   <= RX_IDLE;
                        commit  <= crc_good;
                        drop    <= !crc_good;
                        rx_drop <= !crc_good;
                    end else if (take) begin
                        count <= count + 1'b1;
                    end else begin
                        state <= RX_DISCARD; // rx_er or too long
                    end
                end
                RX_DISCARD: begin
                    if (!rx_dv) begin
                        state   <= RX_IDLE;
                        drop    <= 1'b1;
                        rx_drop <= 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            crc <= crc_init;
        end else if (take) begin
            crc       <= crc32_next_byte(rx_data, crc);
            push_data <= hold[fcs_len-1];
            hold[0]   <= rx_data;
            for (int i = 1; i < fcs_len; i++)
                hold[i] <= hold[i-1];
        end
    end

endmodule

`default_nettype wire

//--- source/mac_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module mac_apb_regs
    import gmii_mac_pkg::*;
#(
    parameter int  MAX_PACKET = 64,
    localparam int LEN_W      = $clog2(MAX_PACKET + 1)
) (
    input  logic             clock,
    input  logic             reset,
    input  logic [31:0]      paddr,
    input  logic             psel,
    input  logic             penable,
    input  logic             pwrite,
    input  logic [31:0]      pwdata,
    output logic [31:0]      prdata,
    output logic             pready,
    output logic             pslverr,
    output logic             tx_push,
    output logic [7:0]       tx_push_data,
    output logic             tx_commit,
    input  logic             tx_space_ok,
    input  logic             tx_slot_free,
    output logic [LEN_W-1:0] rx_rd_offset,
    output logic             rx_release,
    input  logic             rx_head_valid,
    input  logic [LEN_W-1:0] rx_head_len,
    input  logic [7:0]       rx_rd_data,
    input  logic             rx_drop
);

    reg_addr_t        addr;
    logic             access;
    logic             err;
    logic             wr_ok;
    logic             rd_ok;
    logic             tx_pending;    // open tx slot has bytes
    logic [LEN_W-1:0] rx_offset;
    logic [7:0]       drop_count;

    assign addr   = reg_addr_t'(paddr[7:0]);
    assign access = psel && penable;
    assign pready = access;

    always_comb begin
        prdata = '0;
        err    = 1'b0;
        case (addr)
            REG_STATUS: begin
                prdata = {16'h0, drop_count, 6'h0, rx_head_valid, !tx_slot_free};
                err    = pwrite;
            end
            REG_TX_DATA:
                err = !pwrite || !tx_space_ok || !tx_slot_free;
            REG_TX_COMMIT:
                err = !pwrite || !tx_slot_free || !tx_pending;
            REG_RX_LEN: begin
                prdata = 32'(rx_head_len);
                err    = pwrite || !rx_head_valid;
            end
            REG_RX_DATA: begin
                prdata = {24'h0, rx_rd_data}; // offset went out in setup phase
                err    = pwrite || !rx_head_valid;
            end
            REG_RX_NEXT:
                err = !pwrite || !rx_head_valid;
            default:
                err = 1'b1;
        endcase
        if (paddr[31:8] != '0)
            err = 1'b1;
    end

    assign pslverr = access && err;
    assign wr_ok   = access && pwrite && !err;
    assign rd_ok   = access && !pwrite && !err;

    assign tx_push      = wr_ok && addr == REG_TX_DATA;
    assign tx_push_data = pwdata[7:0];
    assign tx_commit    = wr_ok && addr == REG_TX_COMMIT;
    assign rx_release   = wr_ok && addr == REG_RX_NEXT;
    assign rx_rd_offset = rx_offset;

    always_ff @(posedge clock) begin
        if (!reset) begin
            tx_pending <= 1'b0;
            rx_offset  <= '0;
            drop_count <= '0;
        end else begin
            if (tx_commit)
                tx_pending <= 1'b0;
            else if (tx_push)
                tx_pending <= 1'b1;

            if (rx_release)
                rx_offset <= '0;
            else if (rd_ok && addr == REG_RX_DATA && rx_offset != rx_head_len)
                rx_offset <= rx_offset + 1'b1;

            if (rx_drop && drop_count != 8'hff) // saturates
                drop_count <= drop_count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- source/gmii_mac.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_mac #(
    parameter int NUM_SLOTS  = 4,
    parameter int MAX_PACKET = 64
) (
    input  logic        clock,
    input  logic        reset,
    input  logic [31:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [7:0]  tx_data,
    output logic        tx_en,
    input  logic [7:0]  rx_data,
    input  logic        rx_dv,
    input  logic        rx_er
);

    localparam int LEN_W = $clog2(MAX_PACKET + 1);

    logic             tx_push;
    logic [7:0]       tx_push_data;
    logic             tx_commit;
    logic             tx_space_ok;
    logic             tx_slot_free;
    logic [LEN_W-1:0] tx_rd_offset;
    logic             tx_release;
    logic             tx_head_valid;
    logic [LEN_W-1:0] tx_head_len;
    logic [7:0]       tx_rd_data;

    logic             rx_push;
    logic [7:0]       rx_push_data;
    logic             rx_commit;
    logic             rx_ring_drop;
    logic             rx_space_ok;
    logic             rx_slot_free;
    logic [LEN_W-1:0] rx_rd_offset;
    logic             rx_release;
    logic             rx_head_valid;
    logic [LEN_W-1:0] rx_head_len;
    logic [7:0]       rx_rd_data;
    logic             rx_frame_drop;

    mac_apb_regs #(.MAX_PACKET(MAX_PACKET)) regs_i (
        .clock(clock), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tx_push(tx_push), .tx_push_data(tx_push_data), .tx_commit(tx_commit),
        .tx_space_ok(tx_space_ok), .tx_slot_free(tx_slot_free),
        .rx_rd_offset(rx_rd_offset), .rx_release(rx_release),
        .rx_head_valid(rx_head_valid), .rx_head_len(rx_head_len),
        .rx_rd_data(rx_rd_data), .rx_drop(rx_frame_drop)
    );

    packet_ring #(.NUM_SLOTS(NUM_SLOTS), .MAX_PACKET(MAX_PACKET)) tx_ring (
        .clock(clock), .reset(reset),
        .push(tx_push), .push_data(tx_push_data), .commit(tx_commit),
        .drop(1'b0),                                   // host never abandons a slot
        .space_ok(tx_space_ok), .slot_free(tx_slot_free),
        .rd_offset(tx_rd_offset), .release_head(tx_release),
        .head_valid(tx_head_valid), .head_len(tx_head_len), .rd_data(tx_rd_data)
    );

    packet_ring #(.NUM_SLOTS(NUM_SLOTS), .MAX_PACKET(MAX_PACKET)) rx_ring (
        .clock(clock), .reset(reset),
        .push(rx_push), .push_data(rx_push_data), .commit(rx_commit),
        .drop(rx_ring_drop),
        .space_ok(rx_space_ok), .slot_free(rx_slot_free),
        .rd_offset(rx_rd_offset), .release_head(rx_release),
        .head_valid(rx_head_valid), .head_len(rx_head_len), .rd_data(rx_rd_data)
    );

    mac_tx #(.MAX_PACKET(MAX_PACKET)) tx_i (
        .clock(clock), .reset(reset),
        .head_valid(tx_head_valid), .head_len(tx_head_len),
        .rd_offset(tx_rd_offset), .rd_data(tx_rd_data), .release_head(tx_release),
        .tx_data(tx_data), .tx_en(tx_en)
    );

    mac_rx #(.MAX_PACKET(MAX_PACKET)) rx_i (
        .clock(clock), .reset(reset),
        .rx_data(rx_data), .rx_dv(rx_dv), .rx_er(rx_er),
        .push(rx_push), .push_data(rx_push_data), .commit(rx_commit), .drop(rx_ring_drop),
        .space_ok(rx_space_ok), .slot_free(rx_slot_free), .rx_drop(rx_frame_drop)
    );

endmodule

`default_nettype wire

//--- dv/gmii_mac_tb.sv
`timescale 1ns/1ps
`default_nettype none

module gmii_mac_tb
    import gmii_mac_pkg::*;
();

    localparam int NUM_SLOTS   = 4;
    localparam int MAX_PACKET  = 64;
    localparam int MIN_GAP     = 12;
    localparam int NUM_TESTS   = 6;
    localparam int FRAME_TIME  = (8 + MAX_PACKET + 4 + MIN_GAP) + 4 * MAX_PACKET + 16;
    localparam int FRAME_WAIT  = 4 * (MAX_PACKET + 24);
    localparam int CYCLE_LIMIT = 16 + NUM_TESTS * (NUM_SLOTS + 2) * FRAME_TIME;

    logic        clock = 1'b0;
    logic        reset;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [7:0]  tx_data;
    logic        tx_en;
    logic [7:0]  rx_data;
    logic        rx_dv;
    logic        rx_er;
    logic [7:0]  drv_data;
    logic        drv_dv;
    logic        loopback;

    logic [7:0]  frame_buf [MAX_PACKET];
    logic [7:0]  tx_expect [$];      // line image of each loaded frame
    int          tx_expect_len [$];
    logic [7:0]  rx_expect [$];
    int          rx_expect_len [$];
    logic [7:0]  mon_bytes [$];
    int          mon_lens [$];
    int          mon_gaps [$];       // idle cycles ahead of each frame
    int          cur_len = 0;
    int          idle = 0;
    logic [31:0] lfsr = 32'hfb63;
    logic [31:0] rd_word;
    logic [7:0]  drops_expected = 8'h0;
    int          cycles = 0;
    int          tests = 0;
    int          failed = 0;
    int          checks = 0;
    int          errors = 0;
    int          errors_before = 0;

    assign rx_data = loopback ? tx_data : drv_data;
    assign rx_dv   = loopback ? tx_en : drv_dv;

    gmii_mac #(.NUM_SLOTS(NUM_SLOTS), .MAX_PACKET(MAX_PACKET)) gmii_mac_i (
        .clock(clock), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .tx_data(tx_data), .tx_en(tx_en),
        .rx_data(rx_data), .rx_dv(rx_dv), .rx_er(rx_er)
    );

    always #10 clock = ~clock;

    always @(posedge clock) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    // tx line monitor, sampled mid cycle
    always @(negedge clock) begin
        if (tx_en) begin
            if (cur_len == 0)
                mon_gaps.push_back(idle);
            mon_bytes.push_back(tx_data);
            cur_len++;
            idle = 0;
        end else begin
            if (cur_len != 0)
                mon_lens.push_back(cur_len);
            cur_len = 0;
            idle++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at time %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Error at time %0t: %s", $time, what);
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: %0d errors", name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic fill_payload(input int len);
        for (int n = 0; n < len; n++) begin
            for (int b = 0; b < 8; b++) begin
                lfsr = lfsr_step(lfsr);
                frame_buf[n][b] = lfsr[0];
            end
        end
    endtask

    // serial crc over frame_buf, bit 0 of each byte first, register starts at zero
    function automatic logic [31:0] crc_of_frame(input int len);
        logic [31:0] crc;
        logic        fb;
        crc = 32'h0;
        for (int n = 0; n < len; n++) begin
            for (int b = 0; b < 8; b++) begin
                fb  = crc[31] ^ frame_buf[n][b];
                crc = (crc << 1) ^ (fb ? 32'h04C11DB7 : 32'h0);
            end
        end
        return crc;
    endfunction

    // crc msb leaves first, so it lands in bit 0 of fcs byte 0
    function automatic logic [7:0] fcs_from_crc(input logic [31:0] crc, input int k);
        logic [7:0] b;
        for (int j = 0; j < 8; j++)
            b[j] = ~crc[31 - 8 * (k & 3) - j];
        return b;
    endfunction

    function automatic logic [7:0] line_byte(input int i, input int len, input logic [31:0] crc);
        if (i < 7)
            return 8'h55;
        if (i == 7)
            return 8'hD5;
        if (i < 8 + len)
            return frame_buf[i - 8];
        return fcs_from_crc(crc, i - 8 - len);
    endfunction

    task automatic bus_access(input logic [7:0] addr, input logic write,
                              input logic [31:0] wdata, input logic exp_err,
                              output logic [31:0] rdata);
        paddr   = {24'h0, addr};
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clock);
        #2 penable = 1'b1;
        @(negedge clock);
        check_value("pready", pready, 1'b1);
        check_value("pslverr", pslverr, exp_err);
        rdata = prdata;
        @(posedge clock);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_status(input logic has_frame);
        bus_access(REG_STATUS, 1'b0, 32'h0, 1'b0, rd_word);
        check_value("STATUS", rd_word, {16'h0, drops_expected, 6'h0, has_frame, 1'b0});
    endtask

    task automatic expect_rx_payload(input int len);
        for (int i = 0; i < len; i++)
            rx_expect.push_back(frame_buf[i]);
        rx_expect_len.push_back(len);
    endtask

    task automatic load_tx_frame(input int len, input bit overflow);
        logic [31:0] crc;
        crc = crc_of_frame(len);
        for (int i = 0; i < len; i++)
            bus_access(REG_TX_DATA, 1'b1, {24'h0, frame_buf[i]}, 1'b0, rd_word);
        if (overflow)
            bus_access(REG_TX_DATA, 1'b1, 32'h5a, 1'b1, rd_word); // slot already full
        bus_access(REG_TX_COMMIT, 1'b1, 32'h0, 1'b0, rd_word);
        for (int i = 0; i < len + 12; i++)
            tx_expect.push_back(line_byte(i, len, crc));
        tx_expect_len.push_back(len);
    endtask

    task automatic expect_tx_frame();
        int waited;
        int len;
        int gap;
        int exp_len;
        waited = 0;
        while (mon_lens.size() == 0 && waited < FRAME_WAIT) begin
            @(posedge clock);
            #2;
            waited++;
        end
        if (mon_lens.size() == 0) begin
            report_failure("no frame appeared on tx_en");
            return;
        end
        len     = mon_lens.pop_front();
        gap     = mon_gaps.pop_front();
        exp_len = tx_expect_len.pop_front();
        check_value("tx_en cycles", len, exp_len + 12);
        if (gap < MIN_GAP)
            report_failure($sformatf("only %0d idle cycles before a tx frame", gap));
        for (int i = 0; i < len; i++)
            check_value("tx_data", mon_bytes.pop_front(), tx_expect.pop_front());
    endtask

    task automatic drive_frame(input int len, input bit bad_fcs, input int er_pos, input bit keep);
        logic [31:0] crc;
        crc = crc_of_frame(len);
        if (keep)
            expect_rx_payload(len);
        for (int i = 0; i < len + 12; i++) begin
            drv_dv   = 1'b1;
            drv_data = line_byte(i, len, crc);
            if (bad_fcs && i == len + 8)
                drv_data = drv_data ^ 8'h01;
            rx_er = (i == er_pos);
            @(posedge clock);
            #2;
        end
        drv_dv   = 1'b0;
        drv_data = 8'h00;
        rx_er    = 1'b0;
        repeat (MIN_GAP) @(posedge clock);
        #2;
    endtask

    task automatic read_rx_frame();
        int len;
        len = rx_expect_len.pop_front();
        bus_access(REG_RX_LEN, 1'b0, 32'h0, 1'b0, rd_word);
        check_value("RX_LEN", rd_word, len);
        for (int i = 0; i < len; i++) begin
            bus_access(REG_RX_DATA, 1'b0, 32'h0, 1'b0, rd_word);
            check_value("RX_DATA", rd_word, {24'h0, rx_expect.pop_front()});
        end
        bus_access(REG_RX_NEXT, 1'b1, 32'h0, 1'b0, rd_word);
    endtask

    task automatic wait_rx_frame();
        int polls;
        polls   = 0;
        rd_word = '0;
        while (!rd_word[1] && polls < FRAME_WAIT) begin
            bus_access(REG_STATUS, 1'b0, 32'h0, 1'b0, rd_word);
            polls++;
        end
        if (!rd_word[1])
            report_failure("no received frame showed up in STATUS");
    endtask

    task automatic send_tx_frames();
        check_value("tx_en", tx_en, 1'b0);
        check_value("pready", pready, 1'b0);
        check_value("pslverr", pslverr, 1'b0);
        check_status(1'b0);
        fill_payload(20);
        load_tx_frame(20, 1'b0);
        fill_payload(5);
        load_tx_frame(5, 1'b0);   // queued behind the first, tests the gap
        expect_tx_frame();
        expect_tx_frame();
        finish_test("tx format");
    endtask

    task automatic receive_good_frame();
        fill_payload(30);
        drive_frame(30, 1'b0, -1, 1'b1);
        check_status(1'b1);
        read_rx_frame();
        check_status(1'b0);
        finish_test("rx good frame");
    endtask

    task automatic reject_bad_frames();
        fill_payload(16);
        drive_frame(16, 1'b1, -1, 1'b0);
        fill_payload(16);
        drive_frame(16, 1'b0, 8 + 5, 1'b0);  // rx_er on payload byte 5
        drops_expected = drops_expected + 8'd2;
        check_status(1'b0);
        finish_test("rx errors");
    endtask

    task automatic provoke_bus_errors();
        bus_access(REG_TX_COMMIT, 1'b1, 32'h0, 1'b1, rd_word);
        bus_access(REG_RX_LEN, 1'b0, 32'h0, 1'b1, rd_word);
        bus_access(REG_RX_NEXT, 1'b1, 32'h0, 1'b1, rd_word);
        fill_payload(MAX_PACKET);
        load_tx_frame(MAX_PACKET, 1'b1);
        expect_tx_frame();
        finish_test("bus errors");
    endtask

    task automatic overfill_rx_ring();
        for (int k = 0; k <= NUM_SLOTS; k++) begin
            fill_payload(10 + k);
            drive_frame(10 + k, 1'b0, -1, k < NUM_SLOTS);
        end
        drops_expected = drops_expected + 8'd1;
        check_status(1'b1);
        for (int k = 0; k < NUM_SLOTS; k++)
            read_rx_frame();
        check_status(1'b0);
        finish_test("rx ring full");
    endtask

    task automatic loop_frame_back();
        loopback = 1'b1;
        fill_payload(40);
        expect_rx_payload(40);
        load_tx_frame(40, 1'b0);
        expect_tx_frame();
        wait_rx_frame();
        read_rx_frame();
        check_status(1'b0);
        loopback = 1'b0;
        finish_test("loopback");
    endtask

    initial begin
        reset    = 1'b0;
        paddr    = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        pwdata   = '0;
        drv_data = 8'h00;
        drv_dv   = 1'b0;
        rx_er    = 1'b0;
        loopback = 1'b0;
        repeat (16) @(posedge clock);
        #2 reset = 1'b1;
        send_tx_frames();
        receive_good_frame();
        reject_bad_frames();
        provoke_bus_errors();
        overfill_rx_ring();
        loop_frame_back();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", tests, failed, checks, errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
source/gmii_mac_pkg.sv
source/packet_ring.sv
source/mac_tx.sv
source/mac_rx.sv
source/mac_apb_regs.sv
source/gmii_mac.sv
dv/gmii_mac_tb.sv

//--- Makefile
# Verilator build and run of the gmii_mac testbench

VERILATOR ?= verilator
TOP       ?= gmii_mac_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
PASS_TEXT ?= Verification passed
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and search the log"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
